// File: quad_corner_finder.f
design/quad_pkg.sv
design/frame_sync.sv
design/extreme_tracker.sv
design/corner_assign.sv
design/quad_corner_finder.sv
dv/quad_corner_finder_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the quad_corner_finder testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module quad_corner_finder_tb \
    -f quad_corner_finder.f

output=$(./obj_dir/Vquad_corner_finder_tb)
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// File: dv/quad_corner_finder_tb.sv
`timescale 1ns/1ps

module quad_corner_finder_tb import quad_pkg::*; ();

    localparam int num_rows = 6;

    // rectangle drawn while still in pre-init
    localparam int pre_x0 = 5;
    localparam int pre_x1 = 8;
    localparam int pre_y0 = 5;
    localparam int pre_y1 = 8;

    typedef struct packed {
        coord_t        threshold;
        coord_t        x0;
        coord_t        x1;
        coord_t        y0;
        coord_t        y1;
        quad_t         exp_corners;
        thresh_flags_t exp_flags;
    } row_t;

    logic          clk;
    logic          reset;
    logic          vga_vs;
    pixel_t        pixel;
    coord_t        threshold;
    quad_t         corners;
    sync_state_e   state;
    thresh_flags_t thresh_flags;

    row_t        rows [num_rows];
    logic [15:0] lfsr = 16'd56549;
    int          checks = 0;
    int          errors = 0;

    quad_corner_finder #(.frame_width(640), .frame_height(480)) dut (
        .clk          (clk),
        .reset        (reset),
        .vga_vs       (vga_vs),
        .pixel        (pixel),
        .threshold    (threshold),
        .corners      (corners),
        .state        (state),
        .thresh_flags (thresh_flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] take_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_lfsr_bit()};
        end
        return v;
    endfunction

    function automatic row_t make_row(int thr, int x0, int x1, int y0, int y1,
                                      int tl_x, int tl_y, int tr_x, int tr_y,
                                      int bl_x, int bl_y, int br_x, int br_y,
                                      logic [3:0] flags);
        row_t r;
        r.threshold             = coord_t'(thr);
        r.x0                    = coord_t'(x0);
        r.x1                    = coord_t'(x1);
        r.y0                    = coord_t'(y0);
        r.y1                    = coord_t'(y1);
        r.exp_corners.top_left  = {coord_t'(tl_x), coord_t'(tl_y)};
        r.exp_corners.top_right = {coord_t'(tr_x), coord_t'(tr_y)};
        r.exp_corners.bot_left  = {coord_t'(bl_x), coord_t'(bl_y)};
        r.exp_corners.bot_right = {coord_t'(br_x), coord_t'(br_y)};
        r.exp_flags             = thresh_flags_t'(flags);
        return r;
    endfunction

    task automatic fill_table();
        // fit_none: threshold above width 5 and height 4
        rows[0] = make_row(20, 10, 14, 20, 23, 10, 20, 10, 20, 10, 23, 14, 23, 4'b0000);
        // fit_x: tall, height 10 over threshold, width 3 under
        rows[1] = make_row(5, 30, 32, 40, 49, 30, 40, 32, 40, 30, 49, 32, 49, 4'b1100);
        // fit_y: wide, width 12 over threshold, height 3 under
        rows[2] = make_row(5, 100, 111, 7, 9, 100, 7, 111, 7, 100, 9, 111, 9, 4'b0011);
        rows[3] = make_row(2, 200, 205, 300, 304, 200, 300, 205, 300, 200, 304, 205, 304,
                           4'b1111);
        // large frame, then a small one further right and down
        rows[4] = make_row(3, 50, 65, 60, 71, 50, 60, 65, 60, 50, 71, 65, 71, 4'b1111);
        rows[5] = make_row(1, 400, 402, 410, 412, 400, 410, 402, 410, 400, 412, 402, 412,
                           4'b1111);
    endtask

    task automatic check_value(input string name, input logic [87:0] expected,
                               input logic [87:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    function automatic pixel_t idle_pixel();
        pixel_t p;
        p.valid = 1'b0;
        p.x     = coord_t'(take_bits(11));
        p.y     = coord_t'(take_bits(11));
        return p;
    endfunction

    // raster order with 0 to 3 idle cycles ahead of each pixel
    task automatic draw_rect(int x0, int x1, int y0, int y1);
        pixel_t p;
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                repeat (take_bits(2)) begin
                    @(posedge clk);
                    pixel <= idle_pixel();
                end
                p.valid = 1'b1;
                p.x     = coord_t'(x);
                p.y     = coord_t'(y);
                @(posedge clk);
                pixel <= p;
            end
        end
    endtask

    task automatic apply_row(input row_t r, input int idx);
        @(posedge clk);
        threshold <= r.threshold;
        draw_rect(int'(r.x0), int'(r.x1), int'(r.y0), int'(r.y1));
        @(posedge clk);
        pixel  <= idle_pixel();
        vga_vs <= 1'b0;
        // trackers still hold the frame while the falling edge is seen
        @(negedge clk);
        check_value($sformatf("thresh_flags (row %0d)", idx), 88'(r.exp_flags),
                    88'(thresh_flags));
        @(negedge clk);
        check_value($sformatf("corners.top_left (row %0d)", idx),
                    88'(r.exp_corners.top_left), 88'(corners.top_left));
        check_value($sformatf("corners.top_right (row %0d)", idx),
                    88'(r.exp_corners.top_right), 88'(corners.top_right));
        check_value($sformatf("corners.bot_left (row %0d)", idx),
                    88'(r.exp_corners.bot_left), 88'(corners.bot_left));
        check_value($sformatf("corners.bot_right (row %0d)", idx),
                    88'(r.exp_corners.bot_right), 88'(corners.bot_right));
        check_value($sformatf("state (row %0d)", idx), 88'(sync_running), 88'(state));
        @(posedge clk);
        vga_vs <= 1'b1;
    endtask

    initial begin
        int max_px;
        int px;
        int limit_ns;
        @(negedge reset);
        max_px = (pre_x1 - pre_x0 + 1) * (pre_y1 - pre_y0 + 1);
        for (int i = 0; i < num_rows; i++) begin
            px = (int'(rows[i].x1) - int'(rows[i].x0) + 1) *
                 (int'(rows[i].y1) - int'(rows[i].y0) + 1);
            if (px > max_px) begin
                max_px = px;
            end
        end
        limit_ns = 2 * (num_rows + 1) * max_px * 4 * 100;
        #(limit_ns);
        $display("timeout: frames did not finish within %0d ns", limit_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        vga_vs    = 1'b1;
        pixel     = '0;
        threshold = '0;
        fill_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("state after reset", 88'(sync_pre_init), 88'(state));
        check_value("corners after reset", 88'd0, 88'(corners));
        check_value("thresh_flags after reset", 88'd0, 88'(thresh_flags));

        // pre-init frame, threshold zero so any taken pixel would raise a flag
        draw_rect(pre_x0, pre_x1, pre_y0, pre_y1);
        @(posedge clk);
        pixel  <= idle_pixel();
        vga_vs <= 1'b0;
        @(negedge clk);
        check_value("thresh_flags before first sync", 88'd0, 88'(thresh_flags));
        @(negedge clk);
        check_value("state after first sync", 88'(sync_running), 88'(state));
        check_value("corners after first sync", 88'd0, 88'(corners));
        @(posedge clk);
        vga_vs <= 1'b1;

        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i], i);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: design/quad_corner_finder.sv
`timescale 1ns/1ps

module quad_corner_finder import quad_pkg::*; #(
    parameter int frame_width  = 640,
    parameter int frame_height = 480
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          vga_vs,
    input  pixel_t        pixel,
    input  coord_t        threshold,
    output quad_t         corners,
    output sync_state_e   state,
    output thresh_flags_t thresh_flags
);

    logic     running;
    logic     frame_end;
    extreme_t ext_x_max;
    extreme_t ext_x_min;
    extreme_t ext_y_max;
    extreme_t ext_y_min;

    frame_sync u_frame_sync (
        .clk       (clk),
        .reset     (reset),
        .vga_vs    (vga_vs),
        .running   (running),
        .frame_end (frame_end),
        .state     (state)
    );

    extreme_tracker #(.kind(kind_x_max), .frame_width(frame_width),
                      .frame_height(frame_height)) u_x_max (
        .clk(clk), .reset(reset), .pixel(pixel), .running(running),
        .frame_end(frame_end), .extreme(ext_x_max)
    );

    extreme_tracker #(.kind(kind_x_min), .frame_width(frame_width),
                      .frame_height(frame_height)) u_x_min (
        .clk(clk), .reset(reset), .pixel(pixel), .running(running),
        .frame_end(frame_end), .extreme(ext_x_min)
    );

    extreme_tracker #(.kind(kind_y_max), .frame_width(frame_width),
                      .frame_height(frame_height)) u_y_max (
        .clk(clk), .reset(reset), .pixel(pixel), .running(running),
        .frame_end(frame_end), .extreme(ext_y_max)
    );

    extreme_tracker #(.kind(kind_y_min), .frame_width(frame_width),
                      .frame_height(frame_height)) u_y_min (
        .clk(clk), .reset(reset), .pixel(pixel), .running(running),
        .frame_end(frame_end), .extreme(ext_y_min)
    );

    corner_assign u_corner_assign (
        .clk          (clk),
        .reset        (reset),
        .x_max        (ext_x_max),
        .x_min        (ext_x_min),
        .y_max        (ext_y_max),
        .y_min        (ext_y_min),
        .threshold    (threshold),
        .frame_end    (frame_end),
        .corners      (corners),
        .thresh_flags (thresh_flags)
    );

endmodule

// File: design/corner_assign.sv
`timescale 1ns/1ps

module corner_assign import quad_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  extreme_t      x_max,
    input  extreme_t      x_min,
    input  extreme_t      y_max,
    input  extreme_t      y_min,
    input  coord_t        threshold,
    input  logic          frame_end,
    output quad_t         corners,
    output thresh_flags_t thresh_flags
);

    fit_case_e fit;
    quad_t     next_corners;
    logic      x_hit;
    logic      y_hit;

    function automatic point_t mk_point(coord_t px, coord_t py);
        point_t p;
        p.x = px;
        p.y = py;
        return p;
    endfunction

    // zero-extended count so a negative threshold compares as signed
    function automatic logic over(count_t cnt, coord_t thr);
        return $signed({1'b0, cnt}) > $signed({thr[10], thr});
    endfunction

    assign thresh_flags.x_max = over(x_max.count, threshold);
    assign thresh_flags.x_min = over(x_min.count, threshold);
    assign thresh_flags.y_max = over(y_max.count, threshold);
    assign thresh_flags.y_min = over(y_min.count, threshold);

    assign x_hit = thresh_flags.x_max || thresh_flags.x_min;
    assign y_hit = thresh_flags.y_max || thresh_flags.y_min;

    always_comb begin
        if (x_hit && y_hit) begin
            fit = fit_xy;
        end else if (x_hit) begin
            fit = fit_x;
        end else if (y_hit) begin
            fit = fit_y;
        end else begin
            fit = fit_none;
        end
    end

    always_comb begin
        case (fit)
            // long vertical sides, corners at the ends of the x lines
            fit_x: begin
                next_corners.top_left  = mk_point(x_min.edge_pos, x_min.span_lo);
                next_corners.top_right = mk_point(x_max.edge_pos, x_max.span_lo);
                next_corners.bot_left  = mk_point(x_min.edge_pos, x_min.span_hi);
                next_corners.bot_right = mk_point(x_max.edge_pos, x_max.span_hi);
            end
            fit_y: begin
                next_corners.top_left  = mk_point(y_min.span_lo, y_min.edge_pos);
                next_corners.top_right = mk_point(y_min.span_hi, y_min.edge_pos);
                next_corners.bot_left  = mk_point(y_max.span_lo, y_max.edge_pos);
                next_corners.bot_right = mk_point(y_max.span_hi, y_max.edge_pos);
            end
            fit_xy: begin
                next_corners.top_left  = mk_point(x_min.edge_pos, y_min.edge_pos);
                next_corners.top_right = mk_point(x_max.edge_pos, y_min.edge_pos);
                next_corners.bot_left  = mk_point(x_min.edge_pos, y_max.edge_pos);
                next_corners.bot_right = mk_point(x_max.edge_pos, y_max.edge_pos);
            end
            // rotated shape, one corner from each extreme
            default: begin
                next_corners.top_left  = mk_point(x_min.edge_pos, x_min.span_lo);
                next_corners.top_right = mk_point(y_min.span_lo, y_min.edge_pos);
                next_corners.bot_left  = mk_point(y_max.span_lo, y_max.edge_pos);
                next_corners.bot_right = mk_point(x_max.edge_pos, x_max.span_hi);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            corners <= '0;
        end else if (frame_end) begin
            corners <= next_corners;
        end
    end

endmodule

// File: design/extreme_tracker.sv
`timescale 1ns/1ps

module extreme_tracker import quad_pkg::*; #(
    parameter extreme_kind_e kind         = kind_x_max,
    parameter int            frame_width  = 640,
    parameter int            frame_height = 480
) (
    input  logic     clk,
    input  logic     reset,
    input  pixel_t   pixel,
    input  logic     running,
    input  logic     frame_end,
    output extreme_t extreme
);

    localparam bit is_x   = (kind == kind_x_max) || (kind == kind_x_min);
    localparam bit is_max = (kind == kind_x_max) || (kind == kind_y_max);

    localparam coord_t x_last = coord_t'(frame_width - 1);
    localparam coord_t y_last = coord_t'(frame_height - 1);

    // a maximum starts at zero, a minimum at the far side of the frame
    localparam coord_t edge_restart = is_max ? coord_t'(0) : (is_x ? x_last : y_last);
    localparam coord_t span_restart = is_x ? y_last : x_last;

    localparam extreme_t restart_val = '{
        edge_pos: edge_restart,
        span_lo:  span_restart,
        span_hi:  coord_t'(0),
        count:    count_t'(0)
    };

    coord_t primary;
    coord_t secondary;
    logic   hit;

    assign primary   = is_x ? pixel.x : pixel.y;
    assign secondary = is_x ? pixel.y : pixel.x;

    // ties count as hits so a whole line is collected
    assign hit = is_max ? (primary >= extreme.edge_pos) : (primary <= extreme.edge_pos);

    always_ff @(posedge clk) begin
        if (reset || frame_end) begin
            extreme <= restart_val;
        end else if (running && pixel.valid && hit) begin
            extreme.edge_pos <= primary;
            if (secondary > extreme.span_hi) begin
                extreme.span_hi <= secondary;
            end
            if (secondary < extreme.span_lo) begin
                extreme.span_lo <= secondary;
            end
            // a new extreme starts a fresh run
            if (primary == extreme.edge_pos) begin
                extreme.count <= extreme.count + count_t'(1);
            end else begin
                extreme.count <= count_t'(1);
            end
        end
    end

endmodule

// File: design/frame_sync.sv
`timescale 1ns/1ps

module frame_sync import quad_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        vga_vs,
    output logic        running,
    output logic        frame_end,
    output sync_state_e state
);

    logic vs_prev;
    logic vs_fall;

    // edge seen in the same cycle the input drops
    assign vs_fall = vs_prev && !vga_vs;

    always_ff @(posedge clk) begin
        if (reset) begin
            vs_prev <= 1'b0;
            state   <= sync_pre_init;
        end else begin
            vs_prev <= vga_vs;
            if (state == sync_pre_init && vs_fall) begin
                state <= sync_running;
            end
        end
    end

    assign running = (state == sync_running);

    // the edge that leaves pre-init does not end a frame
    assign frame_end = running && vs_fall;

endmodule

// File: design/quad_pkg.sv
package quad_pkg;

    // screen coordinate, signed so off-screen positions stay representable
    typedef logic signed [10:0] coord_t;

    // pixels counted on one extreme line
    typedef logic [10:0] count_t;

    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
    } pixel_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // edge_pos is the extreme of the tracked axis, spans cover the other axis
    typedef struct packed {
        coord_t edge_pos;
        coord_t span_lo;
        coord_t span_hi;
        count_t count;
    } extreme_t;

    typedef struct packed {
        point_t top_left;
        point_t top_right;
        point_t bot_left;
        point_t bot_right;
    } quad_t;

    typedef struct packed {
        logic x_max;
        logic x_min;
        logic y_max;
        logic y_min;
    } thresh_flags_t;

    typedef enum logic {
        sync_pre_init,
        sync_running
    } sync_state_e;

    typedef enum logic [1:0] {
        kind_x_max,
        kind_x_min,
        kind_y_max,
        kind_y_min
    } extreme_kind_e;

    typedef enum logic [1:0] {
        fit_none,
        fit_x,
        fit_y,
        fit_xy
    } fit_case_e;

endpackage
